// File: rv_pkg.sv
package rv_pkg;

	//////////////////////////////////////////////////////////////////////
	// data and instruction types
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] data_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} instr_t;

	// operand source chosen by hazard logic upstream
	typedef enum logic [1:0] {
		fwd_none = 2'b00,
		fwd_ex   = 2'b01,
		fwd_mem  = 2'b10
	} fwd_sel_t;

	//////////////////////////////////////////////////////////////////////
	// opcodes and funct fields
	//////////////////////////////////////////////////////////////////////

	localparam logic [6:0] op_r      = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;

	localparam logic [6:0] funct7_m   = 7'b0000001;
	localparam logic [6:0] funct7_alt = 7'b0100000;

	// integer ops
	localparam logic [2:0] f3_add  = 3'b000;
	localparam logic [2:0] f3_sll  = 3'b001;
	localparam logic [2:0] f3_slt  = 3'b010;
	localparam logic [2:0] f3_sltu = 3'b011;
	localparam logic [2:0] f3_xor  = 3'b100;
	localparam logic [2:0] f3_srl  = 3'b101;
	localparam logic [2:0] f3_or   = 3'b110;
	localparam logic [2:0] f3_and  = 3'b111;

	// branch conditions
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	// M extension
	localparam logic [2:0] f3_mul    = 3'b000;
	localparam logic [2:0] f3_mulh   = 3'b001;
	localparam logic [2:0] f3_mulhsu = 3'b010;
	localparam logic [2:0] f3_div    = 3'b100;
	localparam logic [2:0] f3_rem    = 3'b110;
	localparam logic [2:0] f3_remu   = 3'b111;

	//////////////////////////////////////////////////////////////////////
	// multi-cycle timing
	//////////////////////////////////////////////////////////////////////

	localparam int mul_cycles = 4;
	localparam int div_cycles = 33;

	localparam int mul_cnt_w = $clog2(mul_cycles);
	localparam int div_cnt_w = $clog2(div_cycles);

	// counter value on the last running cycle before done
	localparam logic [mul_cnt_w-1:0] mul_last = mul_cnt_w'(mul_cycles - 2);
	localparam logic [div_cnt_w-1:0] div_last = div_cnt_w'(div_cycles - 2);

endpackage

// File: operand_mux.sv
`timescale 1ns/10ps

module operand_mux (
	input  rv_pkg::instr_t   instr,
	input  rv_pkg::data_t    pc,
	input  rv_pkg::data_t    rs1,
	input  rv_pkg::data_t    rs2,
	input  rv_pkg::data_t    imm,
	input  rv_pkg::data_t    ex_fwd_data,
	input  rv_pkg::data_t    mem_fwd_data,
	input  rv_pkg::fwd_sel_t fwd_a,
	input  rv_pkg::fwd_sel_t fwd_b,
	output rv_pkg::data_t    a,
	output rv_pkg::data_t    b
);

	rv_pkg::data_t reg_a;
	rv_pkg::data_t reg_b;

	// register operands after forwarding
	always_comb begin
		case (fwd_a)
			rv_pkg::fwd_ex:  reg_a = ex_fwd_data;
			rv_pkg::fwd_mem: reg_a = mem_fwd_data;
			default:         reg_a = rs1;
		endcase
		case (fwd_b)
			rv_pkg::fwd_ex:  reg_b = ex_fwd_data;
			rv_pkg::fwd_mem: reg_b = mem_fwd_data;
			default:         reg_b = rs2;
		endcase
	end

	// final operands per opcode
	always_comb begin
		a = reg_a;
		b = reg_b;
		case (instr.opcode)
			rv_pkg::op_lui: begin
				a = '0;
				b = imm;
			end
			rv_pkg::op_auipc: begin
				a = pc;
				b = imm;
			end
			// link address pc+4
			rv_pkg::op_jal, rv_pkg::op_jalr: begin
				a = pc;
				b = 32'd4;
			end
			rv_pkg::op_imm, rv_pkg::op_load, rv_pkg::op_store: b = imm;
			default: ;
		endcase
	end

endmodule

// File: alu_core.sv
`timescale 1ns/10ps

module alu_core (
	input  rv_pkg::instr_t instr,
	input  rv_pkg::data_t  a,
	input  rv_pkg::data_t  b,
	output rv_pkg::data_t  alu_value,
	output logic           rd_wren
);

	logic [4:0]    shamt;
	logic          alt;
	logic          is_sub;
	logic          take;
	rv_pkg::data_t int_value;

	assign shamt  = b[4:0];
	assign alt    = (instr.funct7 == rv_pkg::funct7_alt);
	// addi has no subtract form
	assign is_sub = alt && (instr.opcode == rv_pkg::op_r);

	always_comb begin
		case (instr.funct3)
			rv_pkg::f3_add:  int_value = is_sub ? a - b : a + b;
			rv_pkg::f3_sll:  int_value = a << shamt;
			rv_pkg::f3_slt:  int_value = {31'd0, $signed(a) < $signed(b)};
			rv_pkg::f3_sltu: int_value = {31'd0, a < b};
			rv_pkg::f3_xor:  int_value = a ^ b;
			rv_pkg::f3_srl:  int_value = alt ? 32'($signed(a) >>> shamt) : a >> shamt;
			rv_pkg::f3_or:   int_value = a | b;
			rv_pkg::f3_and:  int_value = a & b;
		endcase
	end

	// branch condition
	always_comb begin
		case (instr.funct3)
			rv_pkg::f3_beq:  take = (a == b);
			rv_pkg::f3_bne:  take = (a != b);
			rv_pkg::f3_blt:  take = ($signed(a) < $signed(b));
			rv_pkg::f3_bge:  take = ($signed(a) >= $signed(b));
			rv_pkg::f3_bltu: take = (a < b);
			rv_pkg::f3_bgeu: take = (a >= b);
			default:         take = 1'b0;
		endcase
	end

	always_comb begin
		case (instr.opcode)
			rv_pkg::op_r, rv_pkg::op_imm: alu_value = int_value;
			rv_pkg::op_branch:            alu_value = {31'd0, take};
			// address and link values
			default:                      alu_value = a + b;
		endcase
	end

	always_comb begin
		case (instr.opcode)
			rv_pkg::op_r, rv_pkg::op_imm, rv_pkg::op_lui, rv_pkg::op_auipc,
			rv_pkg::op_jal, rv_pkg::op_jalr, rv_pkg::op_load: rd_wren = 1'b1;
			default:                                          rd_wren = 1'b0;
		endcase
	end

endmodule

// File: mul_unit.sv
`timescale 1ns/10ps

module mul_unit (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          start,
	input  logic [2:0]    funct3,
	input  rv_pkg::data_t a,
	input  rv_pkg::data_t b,
	output rv_pkg::data_t result,
	output logic          busy,
	output logic          done
);

	logic                         running;
	logic [rv_pkg::mul_cnt_w-1:0] cnt;
	logic                         accept;
	logic                         a_signed;
	logic                         b_signed;
	logic                         sel_hi;
	logic signed [32:0]           op_a;
	logic signed [32:0]           op_b;
	logic signed [49:0]           pp_lo;
	logic signed [49:0]           pp_hi;
	logic [63:0]                  prod;

	// no restart while the finished result is still presented
	assign accept   = start && !running && !done;
	assign a_signed = (funct3 == rv_pkg::f3_mul) || (funct3 == rv_pkg::f3_mulh) ||
		(funct3 == rv_pkg::f3_mulhsu);
	assign b_signed = (funct3 == rv_pkg::f3_mul) || (funct3 == rv_pkg::f3_mulh);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (running) begin
				cnt <= cnt + 1'b1;
				if (cnt == rv_pkg::mul_last) begin
					running <= 1'b0;
					done    <= 1'b1;
				end
			end else if (accept) begin
				running <= 1'b1;
				cnt     <= '0;
			end
		end
	end

	// operands, then partial products, then the 64-bit sum
	always_ff @(posedge clk) begin
		if (accept) begin
			op_a   <= {a_signed & a[31], a};
			op_b   <= {b_signed & b[31], b};
			sel_hi <= (funct3 != rv_pkg::f3_mul);
		end
		if (running) begin
			pp_lo <= $signed({1'b0, op_a[15:0]}) * op_b;
			pp_hi <= $signed(op_a[32:16]) * op_b;
			prod  <= ({{14{pp_hi[49]}}, pp_hi} << 16) + {{14{pp_lo[49]}}, pp_lo};
		end
	end

	assign result = sel_hi ? prod[63:32] : prod[31:0];
	assign busy   = running || (start && !done);

endmodule

// File: div_unit.sv
`timescale 1ns/10ps

module div_unit (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          start,
	input  logic [2:0]    funct3,
	input  rv_pkg::data_t a,
	input  rv_pkg::data_t b,
	output rv_pkg::data_t result,
	output logic          busy,
	output logic          done
);

	logic                         running;
	logic [rv_pkg::div_cnt_w-1:0] cnt;
	logic                         accept;
	logic                         sgn;
	logic                         neg_a;
	logic                         neg_b;
	logic [32:0]                  diff;
	rv_pkg::data_t                dvd;
	rv_pkg::data_t                dvs;
	rv_pkg::data_t                quo;
	rv_pkg::data_t                rem_r;
	logic                         neg_q;
	logic                         neg_r;
	logic                         by_zero;
	logic                         ovf;
	logic                         sel_rem;
	rv_pkg::data_t                q_fix;
	rv_pkg::data_t                r_fix;

	assign accept = start && !running && !done;
	assign sgn    = (funct3 == rv_pkg::f3_div) || (funct3 == rv_pkg::f3_rem);
	assign neg_a  = sgn && a[31];
	assign neg_b  = sgn && b[31];

	// trial subtract of one restoring step
	assign diff = {rem_r, quo[31]} - {1'b0, dvs};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			running <= 1'b0;
			cnt     <= '0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (running) begin
				cnt <= cnt + 1'b1;
				if (cnt == rv_pkg::div_last) begin
					running <= 1'b0;
					done    <= 1'b1;
				end
			end else if (accept) begin
				running <= 1'b1;
				cnt     <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			// setup with magnitudes and sign flags
			quo     <= neg_a ? -a : a;
			dvs     <= neg_b ? -b : b;
			rem_r   <= '0;
			dvd     <= a;
			neg_q   <= neg_a ^ neg_b;
			neg_r   <= neg_a;
			by_zero <= (b == '0);
			ovf     <= sgn && (a == 32'h8000_0000) && (b == 32'hffff_ffff);
			sel_rem <= (funct3 == rv_pkg::f3_rem) || (funct3 == rv_pkg::f3_remu);
		end else if (running) begin
			quo   <= {quo[30:0], ~diff[32]};
			rem_r <= diff[32] ? {rem_r[30:0], quo[31]} : diff[31:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// sign fixup and special cases
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		q_fix = neg_q ? -quo : quo;
		r_fix = neg_r ? -rem_r : rem_r;
		if (by_zero) begin
			q_fix = 32'hffff_ffff;
			r_fix = dvd;
		end else if (ovf) begin
			q_fix = dvd;
			r_fix = '0;
		end
	end

	assign result = sel_rem ? r_fix : q_fix;
	assign busy   = running || (start && !done);

endmodule

// File: execute.sv
`timescale 1ns/10ps

module execute (
	input  logic             clk,
	input  logic             rst_n,

	// forwarding selects
	input  rv_pkg::fwd_sel_t fwd_a,
	input  rv_pkg::fwd_sel_t fwd_b,

	// from decode and register read
	input  rv_pkg::data_t    rs1,
	input  rv_pkg::data_t    pc,
	input  rv_pkg::data_t    rs2,
	input  rv_pkg::data_t    imm,
	input  rv_pkg::instr_t   instr,

	// forwarded results
	input  rv_pkg::data_t    ex_ex_fwd_data,
	input  rv_pkg::data_t    mem_ex_fwd_data,

	output rv_pkg::data_t    alu_result,
	output logic             rd_wren,
	output logic             execute_busy
);

	rv_pkg::data_t a;
	rv_pkg::data_t b;
	rv_pkg::data_t alu_value;
	rv_pkg::data_t mul_result;
	rv_pkg::data_t div_result;
	logic          m_instr;
	logic          mul_start;
	logic          div_start;
	logic          mul_busy;
	logic          div_busy;
	logic          mul_done;
	logic          div_done;

	// funct3[2] of an M op picks the divider
	assign m_instr   = (instr.opcode == rv_pkg::op_r) && (instr.funct7 == rv_pkg::funct7_m);
	assign div_start = m_instr && instr.funct3[2];
	assign mul_start = m_instr && !instr.funct3[2];

	operand_mux u_operand_mux (
		.instr        (instr),
		.pc           (pc),
		.rs1          (rs1),
		.rs2          (rs2),
		.imm          (imm),
		.ex_fwd_data  (ex_ex_fwd_data),
		.mem_fwd_data (mem_ex_fwd_data),
		.fwd_a        (fwd_a),
		.fwd_b        (fwd_b),
		.a            (a),
		.b            (b)
	);

	alu_core u_alu_core (
		.instr     (instr),
		.a         (a),
		.b         (b),
		.alu_value (alu_value),
		.rd_wren   (rd_wren)
	);

	mul_unit u_mul_unit (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (mul_start),
		.funct3 (instr.funct3),
		.a      (a),
		.b      (b),
		.result (mul_result),
		.busy   (mul_busy),
		.done   (mul_done)
	);

	div_unit u_div_unit (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (div_start),
		.funct3 (instr.funct3),
		.a      (a),
		.b      (b),
		.result (div_result),
		.busy   (div_busy),
		.done   (div_done)
	);

	//////////////////////////////////////////////////////////////////////
	// result merge and stall
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		if (mul_done) begin
			alu_result = mul_result;
		end else if (div_done) begin
			alu_result = div_result;
		end else begin
			alu_result = alu_value;
		end
	end

	assign execute_busy = mul_busy || div_busy;

endmodule

// File: tb_execute.sv
`timescale 1ns/10ps

module tb_execute;

	localparam int n_trace   = 32;
	localparam int n_fields  = 12;
	localparam int n_random  = 16;
	localparam int wd_cycles = n_trace * (rv_pkg::div_cycles + 2) + n_random + 50;

	logic             clk;
	logic             rst_n;
	rv_pkg::fwd_sel_t fwd_a;
	rv_pkg::fwd_sel_t fwd_b;
	rv_pkg::data_t    rs1;
	rv_pkg::data_t    pc;
	rv_pkg::data_t    rs2;
	rv_pkg::data_t    imm;
	rv_pkg::instr_t   instr;
	rv_pkg::data_t    ex_ex_fwd_data;
	rv_pkg::data_t    mem_ex_fwd_data;
	rv_pkg::data_t    alu_result;
	logic             rd_wren;
	logic             execute_busy;

	logic [31:0] trace_mem [0:n_trace*n_fields-1];
	// one step with inputs in 0..8 and result, rd_wren and busy cycles in 9..11
	logic [31:0] vec [0:n_fields-1];
	integer      seed;
	int          step;

	execute u_dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.fwd_a           (fwd_a),
		.fwd_b           (fwd_b),
		.rs1             (rs1),
		.pc              (pc),
		.rs2             (rs2),
		.imm             (imm),
		.instr           (instr),
		.ex_ex_fwd_data  (ex_ex_fwd_data),
		.mem_ex_fwd_data (mem_ex_fwd_data),
		.alu_result      (alu_result),
		.rd_wren         (rd_wren),
		.execute_busy    (execute_busy)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else stop_on_error($sformatf("FAILED %s at step %0d: got %h, expected %h",
			name, step, got, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// drive one step, count the stall, check in the cycle busy drops
	//////////////////////////////////////////////////////////////////////

	task automatic run_vec();
		int busy_cnt;
		@(negedge clk);
		fwd_a           = rv_pkg::fwd_sel_t'(vec[0][1:0]);
		fwd_b           = rv_pkg::fwd_sel_t'(vec[1][1:0]);
		instr           = vec[2];
		pc              = vec[3];
		rs1             = vec[4];
		rs2             = vec[5];
		imm             = vec[6];
		ex_ex_fwd_data  = vec[7];
		mem_ex_fwd_data = vec[8];
		// sample mid low phase
		#5;
		busy_cnt = 0;
		while (execute_busy) begin
			busy_cnt++;
			@(negedge clk);
			#5;
		end
		check_value("execute_busy cycles", busy_cnt, vec[11]);
		check_value("alu_result", alu_result, vec[9]);
		check_value("rd_wren", {31'd0, rd_wren}, vec[10]);
	endtask

	// R-type add, xor or sltu on random operands
	task automatic make_random();
		logic [31:0] x;
		logic [31:0] y;
		int          sel;
		x   = $random(seed);
		y   = $random(seed);
		sel = $unsigned($random(seed)) % 3;
		for (int k = 0; k < 9; k++)
			vec[k] = 32'd0;
		vec[4]  = x;
		vec[5]  = y;
		vec[10] = 32'd1;
		vec[11] = 32'd0;
		case (sel)
			0: begin
				vec[2] = {7'd0, 5'd3, 5'd2, 3'b000, 5'd1, rv_pkg::op_r};
				vec[9] = x + y;
			end
			1: begin
				vec[2] = {7'd0, 5'd3, 5'd2, 3'b100, 5'd1, rv_pkg::op_r};
				vec[9] = x ^ y;
			end
			default: begin
				vec[2] = {7'd0, 5'd3, 5'd2, 3'b011, 5'd1, rv_pkg::op_r};
				vec[9] = (x < y) ? 32'd1 : 32'd0;
			end
		endcase
	endtask

	initial begin
		seed            = 4842;
		step            = 0;
		rst_n           = 1'b0;
		fwd_a           = rv_pkg::fwd_none;
		fwd_b           = rv_pkg::fwd_none;
		// addi x0,x0,0 as a nop
		instr           = 32'h0000_0013;
		pc              = '0;
		rs1             = '0;
		rs2             = '0;
		imm             = '0;
		ex_ex_fwd_data  = '0;
		mem_ex_fwd_data = '0;
		$readmemh("execute_trace.txt", trace_mem);
		assert (!$isunknown(trace_mem[n_trace*n_fields-1]))
		else stop_on_error("trace file is missing or shorter than expected");
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_trace; i++) begin
			for (int k = 0; k < n_fields; k++)
				vec[k] = trace_mem[i*n_fields + k];
			step = i;
			run_vec();
		end
		for (int j = 0; j < n_random; j++) begin
			make_random();
			step = n_trace + j;
			run_vec();
		end
		$display("Everything OK");
		$finish;
	end

	// watchdog
	initial begin
		repeat (wd_cycles) @(posedge clk);
		stop_on_error("timeout, the run did not finish within the cycle limit");
	end

endmodule

// File: execute_trace.txt
// fwd_a fwd_b instr pc rs1 rs2 imm ex_fwd mem_fwd
// then expected alu_result, rd_wren and busy cycle count, all hex
0 0 003100B3 00000000 00000007 00000005 00000000 00000000 00000000 0000000C 1 0
0 0 403100B3 00000000 00000005 00000007 00000000 00000000 00000000 FFFFFFFE 1 0
0 0 003110B3 00000000 00000001 0000003F 00000000 00000000 00000000 80000000 1 0
0 0 003120B3 00000000 FFFFFFFE 00000001 00000000 00000000 00000000 00000001 1 0
0 0 003130B3 00000000 FFFFFFFE 00000001 00000000 00000000 00000000 00000000 1 0
0 0 403150B3 00000000 80000000 00000004 00000000 00000000 00000000 F8000000 1 0
0 0 FFB10093 00000000 00000003 00000000 FFFFFFFB 00000000 00000000 FFFFFFFE 1 0
0 0 40415093 00000000 F0000000 00000000 00000404 00000000 00000000 FF000000 1 0
1 2 003100B3 00000000 00000001 00000002 00000000 00000100 00002000 00002100 1 0
2 0 003100B3 00000000 00000001 00000002 00000000 00000100 00002000 00002002 1 0
0 1 003100B3 00000000 00000001 00000002 00000000 00000100 00002000 00000101 1 0
0 0 123450B7 00000000 0000FFFF 00000000 12345000 00000000 00000000 12345000 1 0
0 0 00001097 00000100 00000000 00000000 00001000 00000000 00000000 00001100 1 0
0 0 008000EF 00000200 00000000 00000000 00000008 00000000 00000000 00000204 1 0
0 0 000100E7 00000300 00000040 00000000 00000000 00000000 00000000 00000304 1 0
0 0 01012083 00000000 00001000 00000000 00000010 00000000 00000000 00001010 1 0
0 0 FE312E23 00000000 00002000 DEADBEEF FFFFFFFC 00000000 00000000 00001FFC 0 0
0 0 00314463 00000000 FFFFFFFF 00000001 00000008 00000000 00000000 00000001 0 0
0 0 00310463 00000000 00000005 00000006 00000008 00000000 00000000 00000000 0 0
0 0 023100B3 00000000 FFFFFFFF 00000007 00000000 00000000 00000000 FFFFFFF9 1 4
0 0 023100B3 00000000 FFFFFFFF 00000007 00000000 00000000 00000000 FFFFFFF9 1 4
0 0 023140B3 00000000 FFFFFFF9 00000002 00000000 00000000 00000000 FFFFFFFD 1 21
0 0 023110B3 00000000 80000000 80000000 00000000 00000000 00000000 40000000 1 4
0 0 023120B3 00000000 FFFFFFFF FFFFFFFF 00000000 00000000 00000000 FFFFFFFF 1 4
0 0 023130B3 00000000 FFFFFFFF FFFFFFFF 00000000 00000000 00000000 FFFFFFFE 1 4
0 0 023160B3 00000000 FFFFFFF9 00000002 00000000 00000000 00000000 FFFFFFFF 1 21
0 0 023150B3 00000000 FFFFFFF9 00000002 00000000 00000000 00000000 7FFFFFFC 1 21
0 0 023170B3 00000000 00000064 00000007 00000000 00000000 00000000 00000002 1 21
0 0 023140B3 00000000 00000064 00000000 00000000 00000000 00000000 FFFFFFFF 1 21
0 0 023160B3 00000000 00000064 00000000 00000000 00000000 00000000 00000064 1 21
0 0 023140B3 00000000 80000000 FFFFFFFF 00000000 00000000 00000000 80000000 1 21
0 0 023160B3 00000000 80000000 FFFFFFFF 00000000 00000000 00000000 00000000 1 21

// File: all.f
rv_pkg.sv
operand_mux.sv
alu_core.sv
mul_unit.sv
div_unit.sv
execute.sv
tb_execute.sv
